//--- flist.f
+incdir+design
design/vn_ib_pkg.sv
design/ib_rom_if.sv
design/vn_wr_fsm.sv
design/vn_mem_latch.sv
design/ib_rom.sv
design/ib_ram.sv
design/vn_ib_update.sv
testbench/vn_ib_update_sva.sv
testbench/tb_vn_ib_update.sv

//--- Makefile
TOP := tb_vn_ib_update

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f design/*.sv design/*.svh testbench/*.sv
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- testbench/tb_vn_ib_update.sv
`timescale 1ns/1ps
`include "vn_ib_consts.svh"

module tb_vn_ib_update;
	import vn_ib_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_LOADS  = 29; // every load the run issues, aborted one included
	localparam int LOAD_SPAN  = (`LOAD_CYCLE + 5) + (`LOAD_CYCLE + 2); // load plus read sweep
	localparam int WD_CYCLES  = NUM_LOADS * LOAD_SPAN + 200;          // margin for reset
	localparam int FULL_BUSY  = `LOAD_CYCLE + 3; // busy samples of one full load

	logic       write_clk;
	logic       rstn;
	logic       iter_rqst;
	iter_idx_t  iter_index;
	logic       iter_termination;
	busy_t      busy;
	page_addr_t rd_page_addr;
	rom_word_t  rd_data_a;
	rom_word_t  rd_data_b;

	// reference copy of both ram banks
	rom_word_t               mdl_a [`LOAD_CYCLE];
	rom_word_t               mdl_b [`LOAD_CYCLE];
	logic [`LOAD_CYCLE-1:0]  mdl_known; // page content predictable

	vn_ib_update UUT (
		.write_clk        (write_clk),
		.rstn             (rstn),
		.iter_rqst        (iter_rqst),
		.iter_index       (iter_index),
		.iter_termination (iter_termination),
		.busy             (busy),
		.rd_page_addr     (rd_page_addr),
		.rd_data_a        (rd_data_a),
		.rd_data_b        (rd_data_b)
	);

	initial begin
		write_clk = 1'b0;
		forever #(CLK_PERIOD / 2) write_clk = ~write_clk;
	end

	////////////////////////////////////////////////////////////
	// reporting and compare
	////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input rom_word_t got, input rom_word_t exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp));
	endtask

	task automatic check_busy(input busy_t got, input busy_t exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED busy: got 0x%0h, expected 0x%0h", got, exp));
	endtask

	// content rule of the iteration rom, port 0 is A and 1 is B
	function automatic rom_word_t expected_byte(input int iter, input int port, input int page);
		return rom_word_t'((iter * 16 + page * 3 + port * 128) % 256);
	endfunction

	// whole iteration copied, port A then port B
	function automatic void model_load(input iter_idx_t iter);
		for (int p = 0; p < `LOAD_CYCLE; p++) begin
			mdl_a[page_addr_t'(p)]     = expected_byte(int'(iter), 0, p);
			mdl_b[page_addr_t'(p)]     = expected_byte(int'(iter), 1, p);
			mdl_known[page_addr_t'(p)] = 1'b1;
		end
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus tasks, entered and left on a falling edge
	////////////////////////////////////////////////////////////

	// request sampled on one edge, busy rises on the next
	task automatic start_load(input iter_idx_t iter);
		iter_index = iter;
		iter_rqst  = 1'b1;
		@(negedge write_clk);
		iter_rqst = 1'b0;
		check_busy(busy, NOT_BUSY_IDLE); // request registered, fsm still idle
		@(negedge write_clk);
		check_busy(busy, BUSY);
	endtask

	// counts the busy samples left, then one finish cycle, then idle
	task automatic wait_finish(output int busy_len);
		busy_len = 0;
		while (busy == BUSY) begin
			busy_len++;
			if (busy_len > FULL_BUSY + 8)
				stop_on_error("load never reached the finish state");
			@(negedge write_clk);
		end
		check_busy(busy, NOT_BUSY_FINISH);
		@(negedge write_clk);
		check_busy(busy, NOT_BUSY_IDLE);
	endtask

	task automatic finish_load(input iter_idx_t iter, input int spent);
		int len;
		wait_finish(len);
		if (len != FULL_BUSY - spent)
			stop_on_error($sformatf("FAILED busy cycles: got 0x%0h, expected 0x%0h",
				len + spent, FULL_BUSY));
		model_load(iter);
	endtask

	task automatic full_load(input iter_idx_t iter);
		start_load(iter);
		finish_load(iter, 0);
	endtask

	// read port is registered, data for page p shows one edge later
	task automatic sweep_check();
		for (int p = 0; p < `LOAD_CYCLE; p++) begin
			rd_page_addr = page_addr_t'(p);
			@(negedge write_clk);
			if (mdl_known[page_addr_t'(p)]) begin
				check_word($sformatf("rd_data_a[%0d]", p), rd_data_a, mdl_a[page_addr_t'(p)]);
				check_word($sformatf("rd_data_b[%0d]", p), rd_data_b, mdl_b[page_addr_t'(p)]);
			end
		end
	endtask

	function automatic iter_idx_t rand_iter(input int lo, input int hi);
		return iter_idx_t'($urandom_range(hi, lo));
	endfunction

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		iter_idx_t it;
		int        len;
		int        corner_iter [4]; // group edges of both rom groups
		void'($urandom(32'h16b3_809a));
		rstn             = 1'b0;
		iter_rqst        = 1'b0;
		iter_index       = '0;
		iter_termination = 1'b0;
		rd_page_addr     = '0;
		corner_iter      = '{0, 24, 25, 49};
		for (int p = 0; p < `LOAD_CYCLE; p++) begin
			mdl_a[page_addr_t'(p)] = '0; // unwritten pages read zero
			mdl_b[page_addr_t'(p)] = '0;
		end
		mdl_known = '1;
		repeat (5) @(negedge write_clk);
		rstn = 1'b1;
		@(negedge write_clk);
		check_busy(busy, NOT_BUSY_IDLE);
		sweep_check();

		full_load(rand_iter(0, 24)); // lower rom group
		sweep_check();
		full_load(rand_iter(25, 49)); // upper group through the switch
		sweep_check();
		foreach (corner_iter[i]) begin
			full_load(iter_idx_t'(corner_iter[i]));
			sweep_check();
		end

		// second request from the other group while busy, must be dropped
		it = rand_iter(0, 49);
		start_load(it);
		repeat (5) @(negedge write_clk);
		iter_index = iter_idx_t'((int'(it) + 25) % `ITER_NUM);
		iter_rqst  = 1'b1;
		repeat (3) @(negedge write_clk);
		iter_rqst  = 1'b0;
		finish_load(it, 8);
		sweep_check();

		// abort in RAM_LOAD1, next edge goes to FINISH
		start_load(rand_iter(0, 49));
		repeat (10) @(negedge write_clk);
		iter_termination = 1'b1;
		@(negedge write_clk);
		iter_termination = 1'b0;
		wait_finish(len);
		if (len != 0)
			stop_on_error("termination did not end the load at the next edge");
		mdl_known = '0; // partly rewritten banks
		full_load(rand_iter(0, 49));
		sweep_check();

		repeat (20) begin
			full_load(rand_iter(0, 49));
			sweep_check();
		end

		$display("All tests passed!");
		$finish;
	end

	// watchdog
	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		stop_on_error("watchdog expired before the test sequence completed");
	end

endmodule

//--- testbench/vn_ib_update_sva.sv
`timescale 1ns/1ps
`include "vn_ib_consts.svh"

module vn_ib_update_sva (
	input logic                 write_clk,
	input logic                 rstn,
	input logic                 iter_termination,
	input logic                 ram_write_en,
	input vn_ib_pkg::wr_state_t state
);
	import vn_ib_pkg::*;

	logic [7:0] run_len;   // consecutive write cycles in this burst
	logic       term_seen; // abort seen while the burst was running

	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			run_len   <= '0;
			term_seen <= 1'b0;
		end else if (ram_write_en) begin
			run_len   <= run_len + 8'd1;
			term_seen <= term_seen | iter_termination;
		end else begin
			run_len   <= '0; // next burst starts from zero
			term_seen <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// fsm control outputs
	////////////////////////////////////////////////////////////

	a_wr_in_load: assert property (@(posedge write_clk) disable iff (!rstn)
		ram_write_en |-> (state == RAM_LOAD0 || state == RAM_LOAD1))
		else $error("ram_write_en high outside RAM_LOAD0 and RAM_LOAD1");

	a_finish_once: assert property (@(posedge write_clk) disable iff (!rstn)
		(state == FINISH) |=> (state != FINISH))
		else $error("FINISH lasted more than one cycle");

	// full burst is LOAD_CYCLE writes, shorter only after an abort
	a_burst_len: assert property (@(posedge write_clk) disable iff (!rstn)
		$fell(ram_write_en) |-> ((run_len == 8'(`LOAD_CYCLE)) || term_seen))
		else $error("write burst ended early without iter_termination");

	a_burst_max: assert property (@(posedge write_clk) disable iff (!rstn)
		ram_write_en |-> (run_len < 8'(`LOAD_CYCLE)))
		else $error("write burst longer than LOAD_CYCLE");

endmodule

bind vn_wr_fsm vn_ib_update_sva u_sva (
	.write_clk        (write_clk),
	.rstn             (rstn),
	.iter_termination (iter_termination),
	.ram_write_en     (ram_write_en),
	.state            (state)
);

//--- design/vn_ib_update.sv
`timescale 1ns/1ps
`include "vn_ib_consts.svh"

module vn_ib_update (
	input  logic                   write_clk,
	input  logic                   rstn,
	input  logic                   iter_rqst,
	input  vn_ib_pkg::iter_idx_t   iter_index,      // 0..49, stable while iter_rqst
	input  logic                   iter_termination,
	output vn_ib_pkg::busy_t       busy,
	input  vn_ib_pkg::page_addr_t  rd_page_addr,
	output vn_ib_pkg::rom_word_t   rd_data_a,
	output vn_ib_pkg::rom_word_t   rd_data_b
);
	import vn_ib_pkg::*;

	localparam int IW = `ITER_ADDR_BW;

	logic          rqst_accept;
	logic          rqst_q;       // accepted request, fsm leaves idle one edge later
	logic          grp_sel;      // upper rom group
	iter_idx_t     grp_offset;
	logic          grp_sel_q;
	logic [IW-1:0] grp_iter_q;   // in-group iteration
	logic          rom_port_fetch;
	logic          ram_write_en;
	wr_state_t     state;
	rom_word_t     latch_a;
	rom_word_t     latch_b;

	ib_rom_if rom_bus ();

	////////////////////////////////////////////////////////////
	// request capture
	////////////////////////////////////////////////////////////

	// idle and no request already waiting for the fsm
	assign rqst_accept = iter_rqst && (state == IDLE) && !rqst_q;
	assign grp_sel     = (iter_index >= iter_idx_t'(ITER_PER_GRP));
	assign grp_offset  = grp_sel ? iter_index - iter_idx_t'(ITER_PER_GRP) : iter_index;

	// iteration settles here first, so the latch seeds its base before fetch starts
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			rqst_q     <= 1'b0;
			grp_sel_q  <= 1'b0;
			grp_iter_q <= '0;
		end else begin
			rqst_q <= rqst_accept;
			if (rqst_accept) begin
				grp_sel_q  <= grp_sel;
				grp_iter_q <= IW'(grp_offset); // below 25, fits the group width
			end
		end
	end

	vn_wr_fsm u_fsm (
		.write_clk        (write_clk),
		.rstn             (rstn),
		.iter_rqst        (rqst_q),
		.iter_termination (iter_termination),
		.rom_port_fetch   (rom_port_fetch),
		.ram_write_en     (ram_write_en),
		.busy             (busy),
		.state            (state)
	);

	vn_mem_latch u_latch (
		.write_clk      (write_clk),
		.rstn           (rstn),
		.rom_port_fetch (rom_port_fetch),
		.latch_iter     (grp_iter_q),
		.rom            (rom_bus.requester),
		.latch_in_a     (rom_bus.rd_data_a),
		.latch_in_b     (rom_bus.rd_data_b),
		.latch_out_a    (latch_a),
		.latch_out_b    (latch_b)
	);

	ib_rom u_rom (
		.write_clk   (write_clk),
		.rstn        (rstn),
		.iter_switch (grp_sel_q),
		.rom         (rom_bus.rom)
	);

	ib_ram u_ram (
		.write_clk    (write_clk),
		.rstn         (rstn),
		.write_en     (ram_write_en),
		.wr_data_a    (latch_a),
		.wr_data_b    (latch_b),
		.rd_page_addr (rd_page_addr),
		.rd_data_a    (rd_data_a),
		.rd_data_b    (rd_data_b)
	);

endmodule

//--- design/ib_ram.sv
`timescale 1ns/1ps
`include "vn_ib_consts.svh"

module ib_ram (
	input  logic                   write_clk,
	input  logic                   rstn,
	input  logic                   write_en,
	input  vn_ib_pkg::rom_word_t   wr_data_a,
	input  vn_ib_pkg::rom_word_t   wr_data_b,
	input  vn_ib_pkg::page_addr_t  rd_page_addr, // decoder side
	output vn_ib_pkg::rom_word_t   rd_data_a,
	output vn_ib_pkg::rom_word_t   rd_data_b
);
	import vn_ib_pkg::*;

	localparam int PAGE_NUM = 1 << `PAGE_ADDR_BW;

	rom_word_t           bank_a [PAGE_NUM];
	rom_word_t           bank_b [PAGE_NUM];
	logic [PAGE_NUM-1:0] page_vld;      // page written since reset
	page_addr_t          wr_page_addr;

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////

	// counts up per write, back to page 0 once write_en drops
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn)
			wr_page_addr <= '0;
		else if (!write_en)
			wr_page_addr <= '0;
		else
			wr_page_addr <= wr_page_addr + page_addr_t'(1);
	end

	always_ff @(posedge write_clk) begin
		if (write_en) begin
			bank_a[wr_page_addr] <= wr_data_a; // both banks share the page
			bank_b[wr_page_addr] <= wr_data_b;
		end
	end

	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn)
			page_vld <= '0;
		else if (write_en)
			page_vld[wr_page_addr] <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// decoder read port
	////////////////////////////////////////////////////////////

	// unwritten pages read as zero
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			rd_data_a <= '0;
			rd_data_b <= '0;
		end else if (page_vld[rd_page_addr]) begin
			rd_data_a <= bank_a[rd_page_addr];
			rd_data_b <= bank_b[rd_page_addr];
		end else begin
			rd_data_a <= '0;
			rd_data_b <= '0;
		end
	end

endmodule

//--- design/ib_rom.sv
`timescale 1ns/1ps
`include "vn_ib_consts.svh"

module ib_rom (
	input  logic  write_clk,
	input  logic  rstn,
	input  logic  iter_switch, // 1 selects iterations 25..49
	ib_rom_if.rom rom
);
	import vn_ib_pkg::*;

	localparam int ROM_DEPTH = 1 << `ROM_ADDR_BW;

	rom_word_t grp0_a [ROM_DEPTH]; // iterations 0..24
	rom_word_t grp1_a [ROM_DEPTH]; // iterations 25..49
	rom_word_t grp0_b [ROM_DEPTH];
	rom_word_t grp1_b [ROM_DEPTH];

	rom_word_t grp0_a_q;
	rom_word_t grp1_a_q;
	rom_word_t grp0_b_q;
	rom_word_t grp1_b_q;
	logic      switch_q;

	// contents from the package rule, upper rows of each group are padding
	initial begin
		for (int i = 0; i < ROM_DEPTH; i++) begin
			grp0_a[i] = ib_rom_word(iter_idx_t'(i >> `PAGE_ADDR_BW), 1'b0, page_addr_t'(i));
			grp0_b[i] = ib_rom_word(iter_idx_t'(i >> `PAGE_ADDR_BW), 1'b1, page_addr_t'(i));
			grp1_a[i] = ib_rom_word(iter_idx_t'((i >> `PAGE_ADDR_BW) + ITER_PER_GRP),
				1'b0, page_addr_t'(i));
			grp1_b[i] = ib_rom_word(iter_idx_t'((i >> `PAGE_ADDR_BW) + ITER_PER_GRP),
				1'b1, page_addr_t'(i));
		end
	end

	////////////////////////////////////////////////////////////
	// both groups read at once
	////////////////////////////////////////////////////////////

	always_ff @(posedge write_clk) begin
		grp0_a_q <= grp0_a[rom.rd_addr_a];
		grp1_a_q <= grp1_a[rom.rd_addr_a];
		grp0_b_q <= grp0_b[rom.rd_addr_b];
		grp1_b_q <= grp1_b[rom.rd_addr_b];
	end

	// switch lines up with the registered read data
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn)
			switch_q <= 1'b0;
		else
			switch_q <= iter_switch;
	end

	// group mux
	assign rom.rd_data_a = switch_q ? grp1_a_q : grp0_a_q;
	assign rom.rd_data_b = switch_q ? grp1_b_q : grp0_b_q;

endmodule

//--- design/vn_mem_latch.sv
`timescale 1ns/1ps
`include "vn_ib_consts.svh"

module vn_mem_latch (
	input  logic                     write_clk,
	input  logic                     rstn,
	input  logic                     rom_port_fetch,
	input  logic [`ITER_ADDR_BW-1:0] latch_iter,  // in-group iteration of the request
	ib_rom_if.requester              rom,
	input  vn_ib_pkg::rom_word_t     latch_in_a,
	input  vn_ib_pkg::rom_word_t     latch_in_b,
	output vn_ib_pkg::rom_word_t     latch_out_a,
	output vn_ib_pkg::rom_word_t     latch_out_b
);
	import vn_ib_pkg::*;

	rom_addr_t iter_base;
	rom_addr_t addr_a_q;
	rom_addr_t addr_b_q;

	// first page of the requested iteration
	assign iter_base = {latch_iter, {`PAGE_ADDR_BW{1'b0}}};

	////////////////////////////////////////////////////////////
	// rom address generators
	////////////////////////////////////////////////////////////

	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			addr_a_q <= '0;
			addr_b_q <= '0;
		end else if (!rom_port_fetch) begin
			addr_a_q <= iter_base; // hold at base until fetch starts
			addr_b_q <= iter_base;
		end else begin
			addr_a_q <= addr_a_q + rom_addr_t'(1); // one page per cycle
			addr_b_q <= addr_b_q + rom_addr_t'(1);
		end
	end

	assign rom.rd_addr_a = addr_a_q;
	assign rom.rd_addr_b = addr_b_q;

	////////////////////////////////////////////////////////////
	// data latches
	////////////////////////////////////////////////////////////

	// one more stage after the rom, registered every edge
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			latch_out_a <= '0;
			latch_out_b <= '0;
		end else begin
			latch_out_a <= latch_in_a;
			latch_out_b <= latch_in_b;
		end
	end

endmodule

//--- design/vn_wr_fsm.sv
`timescale 1ns/1ps
`include "vn_ib_consts.svh"

module vn_wr_fsm (
	input  logic                  write_clk,
	input  logic                  rstn,
	input  logic                  iter_rqst,
	input  logic                  iter_termination,
	output logic                  rom_port_fetch, // releases the rom address counters
	output logic                  ram_write_en,
	output vn_ib_pkg::busy_t      busy,
	output vn_ib_pkg::wr_state_t  state
);
	import vn_ib_pkg::*;

	localparam int CNT_W = $clog2(`LOAD_CYCLE);

	wr_state_t        state_nxt;
	logic [CNT_W-1:0] write_cnt;  // writes done in this load
	logic             prime_q;    // second RAM_LOAD0 cycle
	logic             wr_done;    // last page written, drain one cycle
	logic             last_write;

	assign last_write = ram_write_en && (write_cnt == CNT_W'(`LOAD_CYCLE - 1));

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:       if (iter_rqst) state_nxt = ROM_FETCH0;
			ROM_FETCH0: state_nxt = iter_termination ? FINISH : RAM_LOAD0;
			RAM_LOAD0: begin
				if (iter_termination)
					state_nxt = FINISH;    // abort
				else if (prime_q)
					state_nxt = RAM_LOAD1; // latch now holds page 0
			end
			RAM_LOAD1: begin
				if (iter_termination || wr_done)
					state_nxt = FINISH;
			end
			FINISH:     state_nxt = IDLE;  // single cycle
			default:    state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			state     <= IDLE;
			write_cnt <= '0;
			prime_q   <= 1'b0;
			wr_done   <= 1'b0;
		end else begin
			state     <= state_nxt;
			write_cnt <= ram_write_en ? write_cnt + CNT_W'(1) : '0; // clears between loads
			prime_q   <= (state == RAM_LOAD0);
			wr_done   <= (state == RAM_LOAD1) && (wr_done || last_write);
		end
	end

	////////////////////////////////////////////////////////////
	// output decode per state
	////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			ROM_FETCH0: begin
				rom_port_fetch = 1'b1;
				ram_write_en   = 1'b0;
				busy           = BUSY;
			end
			RAM_LOAD0: begin
				rom_port_fetch = 1'b1;
				ram_write_en   = prime_q;  // only once the pipe is primed
				busy           = BUSY;
			end
			RAM_LOAD1: begin
				rom_port_fetch = 1'b1;
				ram_write_en   = !wr_done;
				busy           = BUSY;
			end
			FINISH: begin
				rom_port_fetch = 1'b0;
				ram_write_en   = 1'b0;
				busy           = NOT_BUSY_FINISH;
			end
			default: begin             // IDLE
				rom_port_fetch = 1'b0;
				ram_write_en   = 1'b0;
				busy           = NOT_BUSY_IDLE;
			end
		endcase
	end

endmodule

//--- design/ib_rom_if.sv
`timescale 1ns/1ps

// read bus between the latch address generators and the iteration rom
interface ib_rom_if;
	import vn_ib_pkg::*;

	rom_addr_t rd_addr_a; // port A read address
	rom_addr_t rd_addr_b; // port B read address
	rom_word_t rd_data_a; // registered, one clock after the address
	rom_word_t rd_data_b;

	// address side, owned by vn_mem_latch
	modport requester (
		output rd_addr_a,
		output rd_addr_b,
		input  rd_data_a,
		input  rd_data_b
	);

	// data side, owned by ib_rom
	modport rom (
		input  rd_addr_a,
		input  rd_addr_b,
		output rd_data_a,
		output rd_data_b
	);

endinterface

//--- design/vn_ib_pkg.sv
`include "vn_ib_consts.svh"

package vn_ib_pkg;

	// iterations held by one rom group
	parameter int ITER_PER_GRP = `ITER_NUM / 2;

	typedef logic [`ROM_RD_BW-1:0]      rom_word_t;  // one page byte
	typedef logic [`ROM_ADDR_BW-1:0]    rom_addr_t;  // {iter, page}
	typedef logic [`PAGE_ADDR_BW-1:0]   page_addr_t;
	typedef logic [$clog2(`ITER_NUM)-1:0] iter_idx_t; // 0..49

	// update fsm states, same encoding as the decoder control unit
	typedef enum logic [2:0] {
		IDLE       = 3'b000,
		ROM_FETCH0 = 3'b001, // rom address seeded, first read issued
		RAM_LOAD0  = 3'b010, // two cycles filling rom and latch stages
		RAM_LOAD1  = 3'b011, // streaming writes into both banks
		FINISH     = 3'b100
	} wr_state_t;

	typedef enum logic [1:0] {
		NOT_BUSY_IDLE   = 2'b00,
		BUSY            = 2'b01,
		NOT_BUSY_FINISH = 2'b10
	} busy_t;

	// rom content rule, port 0 is A and port 1 is B
	function automatic rom_word_t ib_rom_word(
		input iter_idx_t  iter,
		input logic       port,
		input page_addr_t page
	);
		int unsigned val;
		val = (int'(iter) * 16 + int'(page) * 3 + int'(port) * 128) % 256;
		return rom_word_t'(val);
	endfunction

endpackage

//--- design/vn_ib_consts.svh
`ifndef VN_IB_CONSTS_SVH
`define VN_IB_CONSTS_SVH

////////////////////////////////////////////////////////////
// rom and page geometry
////////////////////////////////////////////////////////////

`define ROM_RD_BW     8   // one rom read word, a single byte

`define PAGE_ADDR_BW  6   // 64 pages per iteration

`define ITER_ADDR_BW  5   // 25 iterations inside one group

// rom address is {iteration, page}
`define ROM_ADDR_BW   11

////////////////////////////////////////////////////////////
// load sequencing
////////////////////////////////////////////////////////////

`define LOAD_CYCLE    64  // ram writes per iteration load

`define ITER_NUM      50  // iterations over both rom groups

`endif
